// ==== design/byte_lane_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

// four byte-wide banks, two synchronous read-first ports
// port A writes whole words, port B only its enabled lanes
module byte_lane_mem
   import sram_cfg_pkg::*;
(
   input  wire      a_clk_i,

   // word port
   input  wire      a_en_i,
   input  wire      a_we_i,
   input  wadr_t    a_adr_i,
   input  word_t    a_wdat_i,
   output word_t    a_rdat_o,

   // lane-masked port
   input  wire      b_en_i,
   input  wire      b_we_i,
   input  lane_en_t b_lane_en_i,
   input  wadr_t    b_adr_i,
   input  word_t    b_wdat_i,
   output word_t    b_rdat_o
);

   byte_t a_rd_q [LANES];   // per-lane read registers
   byte_t b_rd_q [LANES];

   // -------------------------------------------------------------------------
   //  banks
   // -------------------------------------------------------------------------
   for (genvar l = 0; l < LANES; l++) begin : g_lane
      byte_t bank [WORDS];

      always_ff @(posedge a_clk_i) begin
         // nonblocking reads see the old contents, i.e. read-first
         if (a_en_i) begin
            a_rd_q[l] <= bank[a_adr_i];
         end
         if (b_en_i) begin
            b_rd_q[l] <= bank[b_adr_i];
         end
         if (b_en_i && b_we_i && b_lane_en_i[l]) begin
            bank[b_adr_i] <= b_wdat_i[8*l +: 8];
         end
         if (a_en_i && a_we_i) begin
            bank[a_adr_i] <= a_wdat_i[8*l +: 8];   // A last, A wins
         end
      end

      assign a_rdat_o[8*l +: 8] = a_rd_q[l];
      assign b_rdat_o[8*l +: 8] = b_rd_q[l];
   end

endmodule : byte_lane_mem

`default_nettype wire

// ==== design/narrow_port_adapter.sv ====
`timescale 1ns/1ps
`default_nettype none

// byte port to word memory glue: address split, lane enables,
// write replication and read byte select
module narrow_port_adapter
   import sram_cfg_pkg::*;
(
   input  wire      a_clk_i,
   input  wire      rst_i,

   input  wire      acc_i,      // port B access enabled this cycle
   input  badr_t    badr_i,     // byte address from the bus
   output wadr_t    wadr_o,     // word address to control and memory
   output lane_en_t lane_en_o,  // one-hot lane write enable

   input  byte_t    wbyte_i,    // write byte
   output word_t    wword_o,    // write byte on every lane

   input  word_t    rword_i,    // registered read word from memory
   output byte_t    rbyte_o     // byte picked by the registered lane
);

   lane_t lane;    // lane of the current request
   lane_t lane_q;  // lane of the access now being acked

   // -------------------------------------------------------------------------
   //  request side
   // -------------------------------------------------------------------------
   assign wadr_o    = badr_i[SBITS+LANE_BITS-1:LANE_BITS];
   assign lane      = badr_i[LANE_BITS-1:0];
   assign lane_en_o = lane_en_t'(1) << lane;   // memory masks with these
   assign wword_o   = {LANES{wbyte_i}};

   // -------------------------------------------------------------------------
   //  response side
   // -------------------------------------------------------------------------
   // lane index lines up with the read word, both captured at acceptance
   always_ff @(posedge a_clk_i) begin
      if (rst_i) begin
         lane_q <= '0;
      end else if (acc_i) begin
         lane_q <= lane;
      end
   end

   assign rbyte_o = rword_i[8*lane_q +: 8];   // 0 -> bits 7:0, little-endian

endmodule : narrow_port_adapter

`default_nettype wire

// ==== design/sram_access_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

// combinational collision check between the two ports
// a write on either side to the same word stalls the losing port
module sram_access_ctrl
   import sram_cfg_pkg::*;
   import wb_bus_pkg::*;
(
   // port A request
   input  wire   a_req_i,
   input  wire   a_wr_i,
   input  wadr_t a_adr_i,

   // port B request on its word address
   input  wire   b_req_i,
   input  wire   b_wr_i,
   input  wadr_t b_adr_i,

   // stalls back to the request stages
   output logic  a_stall_o,
   output logic  b_stall_o,

   // memory port enables
   output logic  a_en_o,
   output logic  a_we_o,
   output logic  b_en_o,
   output logic  b_we_o
);

   // -------------------------------------------------------------------------
   //  conflict detect
   // -------------------------------------------------------------------------
   logic       same_word;   // both ports on one word
   logic       conflict;    // ... and somebody writes
   logic [1:0] stall_vec;   // indexed by port_e

   assign same_word = (a_adr_i == b_adr_i);

   // two reads of the same word are harmless
   assign conflict = a_req_i & b_req_i & same_word & (a_wr_i | b_wr_i);

   // the port without priority is held off
   always_comb begin
      stall_vec             = '0;
      stall_vec[~PRIO_PORT] = conflict;   // loser retries next cycle
   end

   assign a_stall_o = stall_vec[PORT_A];
   assign b_stall_o = stall_vec[PORT_B];

   // -------------------------------------------------------------------------
   //  memory enables
   // -------------------------------------------------------------------------
   // enable only what actually gets accepted at this edge
   assign a_en_o = a_req_i & ~a_stall_o;
   assign a_we_o = a_en_o & a_wr_i;
   assign b_en_o = b_req_i & ~b_stall_o;
   assign b_we_o = b_en_o & b_wr_i;

endmodule : sram_access_ctrl

`default_nettype wire

// ==== design/sram_cfg_pkg.sv ====
`default_nettype none

// ---------------------------------------------------------------------------
//  memory geometry and data types shared by the SRAM datapath
// ---------------------------------------------------------------------------
package sram_cfg_pkg;

   // word-address width, sets the depth of every bank
   localparam int SBITS = 10;
   localparam int WORDS = 1 << SBITS;       // words per bank

   // byte lanes per word, lane 0 = bits 7:0 (little-endian)
   localparam int LANES     = 4;
   localparam int LANE_BITS = $clog2(LANES); // low byte-address bits

   // data payloads
   typedef logic [8*LANES-1:0] word_t;      // full 32-bit word
   typedef logic [7:0]         byte_t;      // one lane

   // addresses
   typedef logic [SBITS-1:0]           wadr_t; // word address, port A view
   typedef logic [SBITS+LANE_BITS-1:0] badr_t; // byte address, port B view

   // lane selection
   typedef logic [LANE_BITS-1:0] lane_t;    // lane index
   typedef logic [LANES-1:0]     lane_en_t; // one-hot lane write enable

endpackage : sram_cfg_pkg

`default_nettype wire

// ==== design/wb_bus_pkg.sv ====
`default_nettype none

// ---------------------------------------------------------------------------
//  pipelined wishbone-style bus constants
// ---------------------------------------------------------------------------
package wb_bus_pkg;

   // cycles from acceptance edge to ack, read data valid with ack
   localparam int ACK_LAT = 1;

   // port identifiers, used for priority and in messages
   typedef enum logic [0:0] {
      PORT_A = 1'b0,   // 32-bit word port
      PORT_B = 1'b1    // 8-bit byte port
   } port_e;

   // port that wins a same-word collision
   localparam port_e PRIO_PORT = PORT_A;

endpackage : wb_bus_pkg

`default_nettype wire

// ==== design/wb_req_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// per-port request front end: request/write flags out to the arbiter,
// wat back to the master, ack pipeline of ACK_LAT stages
module wb_req_stage
   import wb_bus_pkg::*;
#(
   parameter type dat_t = logic [7:0]   // payload, word or byte
) (
   input  wire  a_clk_i,
   input  wire  rst_i,

   // master side
   input  wire  cyc_i,
   input  wire  stb_i,
   input  wire  we_i,
   input  dat_t wdat_i,
   output logic ack_o,
   output logic wat_o,

   // towards arbiter and memory
   input  wire  stall_i,   // conflict stall from access control
   output logic req_o,     // request present this cycle
   output logic wr_o,      // request is a write
   output dat_t wdat_o     // write data, qualified by wr_o
);

   // -------------------------------------------------------------------------
   //  request decode
   // -------------------------------------------------------------------------
   logic                 acc;       // accepted at the coming edge
   logic [ACK_LAT-1:0]   ack_pipe;  // in-flight acks, oldest at the top

   assign req_o  = cyc_i & stb_i;
   assign wr_o   = req_o & we_i;          // write only with a live request
   assign wdat_o = wdat_i;                // payload follows the write flag
   assign wat_o  = stall_i;               // stall is the pipelined wat
   assign acc    = req_o & ~stall_i;

   // -------------------------------------------------------------------------
   //  ack pipeline
   // -------------------------------------------------------------------------
   always_ff @(posedge a_clk_i) begin
      if (rst_i) begin
         ack_pipe <= '0;
      end else if (!cyc_i) begin
         ack_pipe <= '0;                  // cycle dropped, forget pending acks
      end else begin
         ack_pipe[0] <= acc;
         for (int i = 1; i < ACK_LAT; i++) begin
            ack_pipe[i] <= ack_pipe[i-1]; // only matters if ACK_LAT > 1
         end
      end
   end

   // squash in the ack cycle itself when the master lets go of cyc
   assign ack_o = ack_pipe[ACK_LAT-1] & cyc_i;

endmodule : wb_req_stage

`default_nettype wire

// ==== design/wb_sram_dual_port.sv ====
`timescale 1ns/1ps
`default_nettype none

// shared SRAM, 32-bit port A and 8-bit port B on one clock
module wb_sram_dual_port
   import sram_cfg_pkg::*;
(
   input  wire   a_clk_i,
   input  wire   rst_i,

   // port A, word wide
   input  wire   a_cyc_i,
   input  wire   a_stb_i,
   input  wire   a_we_i,
   input  wadr_t a_adr_i,
   input  word_t a_dat_i,
   output logic  a_ack_o,
   output logic  a_wat_o,
   output word_t a_dat_o,

   // port B, byte wide
   input  wire   b_cyc_i,
   input  wire   b_stb_i,
   input  wire   b_we_i,
   input  badr_t b_adr_i,
   input  byte_t b_dat_i,
   output logic  b_ack_o,
   output logic  b_wat_o,
   output byte_t b_dat_o
);

   // -------------------------------------------------------------------------
   //  internal nets
   // -------------------------------------------------------------------------
   logic     a_req, a_wr, a_stall, a_en, a_we;
   logic     b_req, b_wr, b_stall, b_en, b_we;
   word_t    a_wdat;
   byte_t    b_wdat;
   wadr_t    b_wadr;      // port B word address
   lane_en_t b_lane_en;
   word_t    b_wword;     // replicated write byte
   word_t    b_rword;     // raw read word for the byte select

   // -------------------------------------------------------------------------
   //  request stages
   // -------------------------------------------------------------------------
   wb_req_stage #(.dat_t(word_t)) a_stage_inst (
      .a_clk_i (a_clk_i), .rst_i  (rst_i),
      .cyc_i   (a_cyc_i), .stb_i  (a_stb_i), .we_i  (a_we_i),
      .wdat_i  (a_dat_i), .ack_o  (a_ack_o), .wat_o (a_wat_o),
      .stall_i (a_stall), .req_o  (a_req),   .wr_o  (a_wr),
      .wdat_o  (a_wdat)
   );

   wb_req_stage #(.dat_t(byte_t)) b_stage_inst (
      .a_clk_i (a_clk_i), .rst_i  (rst_i),
      .cyc_i   (b_cyc_i), .stb_i  (b_stb_i), .we_i  (b_we_i),
      .wdat_i  (b_dat_i), .ack_o  (b_ack_o), .wat_o (b_wat_o),
      .stall_i (b_stall), .req_o  (b_req),   .wr_o  (b_wr),
      .wdat_o  (b_wdat)
   );

   // -------------------------------------------------------------------------
   //  byte port glue, arbitration, storage
   // -------------------------------------------------------------------------
   narrow_port_adapter adapter_inst (
      .a_clk_i (a_clk_i), .rst_i     (rst_i),    .acc_i   (b_en),
      .badr_i  (b_adr_i), .wadr_o    (b_wadr),   .lane_en_o (b_lane_en),
      .wbyte_i (b_wdat),  .wword_o   (b_wword),
      .rword_i (b_rword), .rbyte_o   (b_dat_o)
   );

   sram_access_ctrl ctrl_inst (
      .a_req_i   (a_req),   .a_wr_i    (a_wr),    .a_adr_i (a_adr_i),
      .b_req_i   (b_req),   .b_wr_i    (b_wr),    .b_adr_i (b_wadr),
      .a_stall_o (a_stall), .b_stall_o (b_stall),
      .a_en_o    (a_en),    .a_we_o    (a_we),
      .b_en_o    (b_en),    .b_we_o    (b_we)
   );

   byte_lane_mem mem_inst (
      .a_clk_i     (a_clk_i),
      .a_en_i      (a_en),      .a_we_i   (a_we),    .a_adr_i (a_adr_i),
      .a_wdat_i    (a_wdat),    .a_rdat_o (a_dat_o),
      .b_en_i      (b_en),      .b_we_i   (b_we),
      .b_lane_en_i (b_lane_en), .b_adr_i  (b_wadr),
      .b_wdat_i    (b_wword),   .b_rdat_o (b_rword)
   );

endmodule : wb_sram_dual_port

`default_nettype wire

// ==== flist.f ====
design/sram_cfg_pkg.sv
design/wb_bus_pkg.sv
design/wb_req_stage.sv
design/narrow_port_adapter.sv
design/sram_access_ctrl.sv
design/byte_lane_mem.sv
design/wb_sram_dual_port.sv
tests/tb_wb_sram_dual_port.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the dual-port SRAM testbench with Verilator.
# The exit status is the simulator's: nonzero on build failure or $fatal.

cd "$(dirname "$0")"
status=$?
if [ $status -ne 0 ]; then
   echo "cannot enter project root"
   exit $status
fi

verilator --binary --timing \
   -f flist.f \
   --top-module tb_wb_sram_dual_port \
   -Mdir obj_dir \
   -o sim_tb
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed"
   exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

exit 0

// ==== tests/tb_wb_sram_dual_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_wb_sram_dual_port
   import sram_cfg_pkg::*;
   import wb_bus_pkg::*;
;

   // ------------------------------------------------------------------------
   //  run length in clock cycles per directed test
   // ------------------------------------------------------------------------
   localparam int N_RAND       = 16;              // random words in test 2
   localparam int RESET_CYC    = 2 + 2;           // reset plus idle checks
   localparam int RAND_CYC     = 2 * N_RAND * 2;  // writes then reads of 2 cycles each
   localparam int LANE_CYC     = 10 * 2;          // 6 single accesses + 4 reads
   localparam int BURST_CYC    = 9 * 2 + 9 + 2;   // setup, burst, check read
   localparam int CONFLICT_CYC = 3 + 2;
   localparam int SHARED_CYC   = 2;
   localparam int TEST_CYC     = RESET_CYC + RAND_CYC + LANE_CYC + BURST_CYC
                                 + CONFLICT_CYC + SHARED_CYC;
   localparam int TIMEOUT_CYC  = TEST_CYC * 2 + 100;
   localparam int MAX_WAT      = 8;               // stalled cycles before giving up

   logic  a_clk_i;
   logic  rst_i;
   logic  a_cyc_i, a_stb_i, a_we_i;
   wadr_t a_adr_i;
   word_t a_dat_i;
   logic  a_ack_o, a_wat_o;
   word_t a_dat_o;
   logic  b_cyc_i, b_stb_i, b_we_i;
   badr_t b_adr_i;
   byte_t b_dat_i;
   logic  b_ack_o, b_wat_o;
   byte_t b_dat_o;

   word_t model [WORDS];   // expected memory contents
   int    seed;
   int    cycle_cnt = 0;

   wb_sram_dual_port wb_sram_dual_port_inst (
      .a_clk_i (a_clk_i), .rst_i   (rst_i),
      .a_cyc_i (a_cyc_i), .a_stb_i (a_stb_i), .a_we_i (a_we_i),
      .a_adr_i (a_adr_i), .a_dat_i (a_dat_i),
      .a_ack_o (a_ack_o), .a_wat_o (a_wat_o), .a_dat_o (a_dat_o),
      .b_cyc_i (b_cyc_i), .b_stb_i (b_stb_i), .b_we_i (b_we_i),
      .b_adr_i (b_adr_i), .b_dat_i (b_dat_i),
      .b_ack_o (b_ack_o), .b_wat_o (b_wat_o), .b_dat_o (b_dat_o)
   );

   initial begin
      a_clk_i = 1'b0;
      forever #10 a_clk_i = ~a_clk_i;   // 20 ns period
   end

   // hard stop if something never finishes
   always @(posedge a_clk_i) begin
      cycle_cnt++;
      if (cycle_cnt == TIMEOUT_CYC) begin
         abort_run($sformatf("timeout, run did not finish in %0d cycles", TIMEOUT_CYC));
      end
   end

   // ------------------------------------------------------------------------
   //  failure reporting and compares
   // ------------------------------------------------------------------------
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         abort_run($sformatf("ERR %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_byte(input string name, input byte_t got, input byte_t exp);
      if (got !== exp) begin
         abort_run($sformatf("ERR %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("ERR %s got %h expected %h", name, got, exp));
      end
   endtask

   // sampled at the falling edge one cycle after the acceptance edge
   task automatic expect_ack(input port_e p);
      logic ack;
      ack = (p == PORT_A) ? a_ack_o : b_ack_o;
      if (ack !== 1'b1) begin
         abort_run($sformatf("port %s gave no ack one cycle after acceptance", p.name()));
      end
   endtask

   // little-endian lane overlay with lane 0 at bits 7:0
   function automatic word_t put_byte(input word_t w, input lane_t l, input byte_t b);
      word_t r;
      r = w;
      r[8*l +: 8] = b;
      return r;
   endfunction

   // ------------------------------------------------------------------------
   //  bus tasks start and end 2 ns after a rising edge
   // ------------------------------------------------------------------------
   task automatic wait_accept(input port_e p);   // returns just past the acceptance edge
      logic wat;
      int   tries;
      tries = 0;
      do begin
         @(negedge a_clk_i);
         wat = (p == PORT_A) ? a_wat_o : b_wat_o;
         @(posedge a_clk_i);
         #2;
         tries++;
         if (wat && tries == MAX_WAT) begin
            abort_run($sformatf("port %s request never accepted, wat stuck high", p.name()));
         end
      end while (wat);
   endtask

   task automatic bus_a_write(input wadr_t adr, input word_t dat);
      a_cyc_i = 1'b1;
      a_stb_i = 1'b1;
      a_we_i  = 1'b1;
      a_adr_i = adr;
      a_dat_i = dat;
      wait_accept(PORT_A);
      a_stb_i = 1'b0;
      a_we_i  = 1'b0;
      @(negedge a_clk_i);
      expect_ack(PORT_A);
      @(posedge a_clk_i);
      #2;
      a_cyc_i    = 1'b0;
      model[adr] = dat;
   endtask

   task automatic bus_a_read(input wadr_t adr, input word_t exp);
      a_cyc_i = 1'b1;
      a_stb_i = 1'b1;
      a_we_i  = 1'b0;
      a_adr_i = adr;
      wait_accept(PORT_A);
      a_stb_i = 1'b0;
      @(negedge a_clk_i);
      expect_ack(PORT_A);
      check_word("a_dat_o", a_dat_o, exp);
      @(posedge a_clk_i);
      #2;
      a_cyc_i = 1'b0;
   endtask

   task automatic bus_b_write(input wadr_t w, input lane_t l, input byte_t dat);
      b_cyc_i = 1'b1;
      b_stb_i = 1'b1;
      b_we_i  = 1'b1;
      b_adr_i = {w, l};   // word address above the lane bits
      b_dat_i = dat;
      wait_accept(PORT_B);
      b_stb_i = 1'b0;
      b_we_i  = 1'b0;
      @(negedge a_clk_i);
      expect_ack(PORT_B);
      @(posedge a_clk_i);
      #2;
      b_cyc_i  = 1'b0;
      model[w] = put_byte(model[w], l, dat);
   endtask

   task automatic bus_b_read(input wadr_t w, input lane_t l, input byte_t exp);
      b_cyc_i = 1'b1;
      b_stb_i = 1'b1;
      b_we_i  = 1'b0;
      b_adr_i = {w, l};
      wait_accept(PORT_B);
      b_stb_i = 1'b0;
      @(negedge a_clk_i);
      expect_ack(PORT_B);
      check_byte("b_dat_o", b_dat_o, exp);
      @(posedge a_clk_i);
      #2;
      b_cyc_i = 1'b0;
   endtask

   // ------------------------------------------------------------------------
   //  directed tests
   // ------------------------------------------------------------------------
   task automatic test_reset_idle();
      repeat (2) begin
         @(negedge a_clk_i);
         check_bit("a_ack_o", a_ack_o, 1'b0);
         check_bit("b_ack_o", b_ack_o, 1'b0);
         check_bit("a_wat_o", a_wat_o, 1'b0);
         check_bit("b_wat_o", b_wat_o, 1'b0);
         @(posedge a_clk_i);
         #2;
      end
   endtask

   task automatic test_rand_words();
      logic [31:0] r;
      wadr_t       adr_q [N_RAND];
      for (int i = 0; i < N_RAND; i++) begin
         r        = $random(seed);
         adr_q[i] = r[SBITS-1:0];
         r        = $random(seed);
         bus_a_write(adr_q[i], r);
      end
      // model keeps the last write if an address repeats
      for (int i = 0; i < N_RAND; i++) begin
         bus_a_read(adr_q[i], model[adr_q[i]]);
      end
   endtask

   task automatic test_byte_lanes();
      logic [31:0] r;
      byte_t       b [LANES];
      for (int l = 0; l < LANES; l++) begin
         r    = $random(seed);
         b[l] = r[7:0];
         bus_b_write(10'h3f0, lane_t'(l), b[l]);
      end
      bus_a_read(10'h3f0, {b[3], b[2], b[1], b[0]});   // lane 0 lowest
      for (int l = 0; l < LANES; l++) begin
         r    = $random(seed);
         b[l] = r[7:0];
      end
      bus_a_write(10'h3f1, {b[3], b[2], b[1], b[0]});
      for (int l = 0; l < LANES; l++) begin
         bus_b_read(10'h3f1, lane_t'(l), b[l]);
      end
   endtask

   task automatic test_a_burst();
      logic [31:0] r;
      wadr_t       base;
      base = 10'h100;
      for (int i = 0; i < 8; i++) begin
         r = $random(seed);
         bus_a_write(base + wadr_t'(i), r);
      end
      r = $random(seed);
      bus_a_write(10'h200, r);   // other word that B hits mid burst
      a_cyc_i = 1'b1;
      a_we_i  = 1'b0;
      for (int i = 0; i <= 8; i++) begin
         a_stb_i = (i < 8);
         a_adr_i = base + wadr_t'(i);
         if (i == 3) begin
            r       = $random(seed);
            b_cyc_i = 1'b1;
            b_stb_i = 1'b1;
            b_we_i  = 1'b1;
            b_adr_i = {10'h200, 2'd1};
            b_dat_i = r[7:0];
         end else if (i == 4) begin
            b_stb_i = 1'b0;
            b_we_i  = 1'b0;
         end else if (i == 5) begin
            b_cyc_i = 1'b0;
         end
         @(negedge a_clk_i);
         if (i < 8) check_bit("a_wat_o", a_wat_o, 1'b0);
         if (i == 0) check_bit("a_ack_o", a_ack_o, 1'b0);
         if (i > 0) begin
            expect_ack(PORT_A);   // one ack per cycle in request order
            check_word("a_dat_o", a_dat_o, model[base + wadr_t'(i - 1)]);
         end
         if (i == 3) check_bit("b_wat_o", b_wat_o, 1'b0);
         if (i == 4) expect_ack(PORT_B);
         @(posedge a_clk_i);
         #2;
      end
      a_cyc_i        = 1'b0;
      model[10'h200] = put_byte(model[10'h200], 2'd1, r[7:0]);
      bus_a_read(10'h200, model[10'h200]);
   endtask

   task automatic test_write_conflict();
      logic [31:0] ra, rb;
      ra      = $random(seed);
      rb      = $random(seed);
      a_cyc_i = 1'b1;
      a_stb_i = 1'b1;
      a_we_i  = 1'b1;
      a_adr_i = 10'h2a0;
      a_dat_i = ra;
      b_cyc_i = 1'b1;
      b_stb_i = 1'b1;
      b_we_i  = 1'b1;
      b_adr_i = {10'h2a0, 2'd2};
      b_dat_i = rb[7:0];
      @(negedge a_clk_i);
      check_bit("a_wat_o", a_wat_o, 1'b0);
      check_bit("b_wat_o", b_wat_o, 1'b1);   // A has priority
      @(posedge a_clk_i);
      #2;
      a_stb_i = 1'b0;   // B holds its request
      a_we_i  = 1'b0;
      @(negedge a_clk_i);
      expect_ack(PORT_A);
      check_bit("b_wat_o", b_wat_o, 1'b0);
      check_bit("b_ack_o", b_ack_o, 1'b0);
      @(posedge a_clk_i);
      #2;
      b_stb_i = 1'b0;
      b_we_i  = 1'b0;
      @(negedge a_clk_i);
      expect_ack(PORT_B);
      check_bit("a_ack_o", a_ack_o, 1'b0);   // A acked only once
      @(posedge a_clk_i);
      #2;
      a_cyc_i        = 1'b0;
      b_cyc_i        = 1'b0;
      model[10'h2a0] = put_byte(ra, 2'd2, rb[7:0]);   // B lands on top of A
      bus_a_read(10'h2a0, model[10'h2a0]);
   endtask

   task automatic test_shared_read();
      word_t exp;
      exp     = model[10'h3f1];
      a_cyc_i = 1'b1;
      a_stb_i = 1'b1;
      a_we_i  = 1'b0;
      a_adr_i = 10'h3f1;
      b_cyc_i = 1'b1;
      b_stb_i = 1'b1;
      b_we_i  = 1'b0;
      b_adr_i = {10'h3f1, 2'd3};
      @(negedge a_clk_i);
      check_bit("a_wat_o", a_wat_o, 1'b0);   // two reads never collide
      check_bit("b_wat_o", b_wat_o, 1'b0);
      @(posedge a_clk_i);
      #2;
      a_stb_i = 1'b0;
      b_stb_i = 1'b0;
      @(negedge a_clk_i);
      expect_ack(PORT_A);
      expect_ack(PORT_B);
      check_word("a_dat_o", a_dat_o, exp);
      check_byte("b_dat_o", b_dat_o, exp[31:24]);
      @(posedge a_clk_i);
      #2;
      a_cyc_i = 1'b0;
      b_cyc_i = 1'b0;
   endtask

   // ------------------------------------------------------------------------
   //  main sequence
   // ------------------------------------------------------------------------
   initial begin
      seed    = 32'h4411a5ee;
      rst_i   = 1'b1;
      a_cyc_i = 1'b0;
      a_stb_i = 1'b0;
      a_we_i  = 1'b0;
      a_adr_i = '0;
      a_dat_i = '0;
      b_cyc_i = 1'b0;
      b_stb_i = 1'b0;
      b_we_i  = 1'b0;
      b_adr_i = '0;
      b_dat_i = '0;
      for (int i = 0; i < WORDS; i++) model[i] = '0;
      repeat (2) @(posedge a_clk_i);
      #2;
      rst_i = 1'b0;
      test_reset_idle();
      test_rand_words();
      test_byte_lanes();
      test_a_burst();
      test_write_conflict();
      test_shared_read();
      $display("NO ERRORS");
      $finish;
   end

endmodule : tb_wb_sram_dual_port

`default_nettype wire
